//--- verilog/mold_settings.svh
/*
 * MoldUDP64 receiver widths and sizes
 * beat geometry, header field widths and byte buffer depth
 */
`ifndef MOLD_SETTINGS_SVH
`define MOLD_SETTINGS_SVH

`define MOLD_DATA_W     64
`define MOLD_KEEP_W     8
`define MOLD_SID_W      80
`define MOLD_SEQ_W      64
// length and message count fields
`define MOLD_ML_W       16
`define MOLD_HDR_BYTES  20
`define MOLD_BUF_BYTES  24
// byte count 0..8
`define MOLD_CNT_W      4
`define MOLD_FILL_W     5

`endif

//--- verilog/mold_pkg.sv
/*
 * MoldUDP64 receiver types
 * input beat, decoded header, buffer push, output word and message identity
 */
`include "mold_settings.svh"
`default_nettype none

package mold_pkg;

	typedef struct packed {
		logic                    valid;
		logic                    last;
		logic [`MOLD_KEEP_W-1:0] keep;
		logic [`MOLD_DATA_W-1:0] data;
	} axis_beat_t;

	typedef struct packed {
		logic [`MOLD_SID_W-1:0] sid;
		logic [`MOLD_SEQ_W-1:0] seq;
		logic [`MOLD_ML_W-1:0]  msg_cnt;
	} mold_header_t;

	// bytes packed into the low lanes
	typedef struct packed {
		logic [`MOLD_CNT_W-1:0]  cnt;
		logic [`MOLD_DATA_W-1:0] data;
	} byte_push_t;

	typedef struct packed {
		logic                    valid;
		logic                    start;
		logic                    last;
		logic [`MOLD_KEEP_W-1:0] mask;
		logic [`MOLD_DATA_W-1:0] data;
	} mold_word_t;

	typedef struct packed {
		logic [`MOLD_SID_W-1:0] sid;
		logic [`MOLD_SEQ_W-1:0] seq;
	} mold_id_t;

endpackage

`default_nettype wire

//--- verilog/mold_header_parse.sv
/*
 * MoldUDP64 header parser
 * counts beats within a packet, assembles the 20 byte header into a
 * one-entry slot and forwards payload bytes to the byte buffer
 */
`include "mold_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module mold_header_parse
	import mold_pkg::*;
(
	input  wire          clk,
	input  wire          nreset,
	input  axis_beat_t   beat_i,
	input  wire          room_i,
	input  wire          hdr_take_i,
	output logic         tready_o,
	output byte_push_t   push_o,
	output mold_header_t hdr_o,
	output logic         hdr_valid_o
);

// header bytes carried by beat 2
localparam int HDR_LANES = `MOLD_HDR_BYTES - 2 * `MOLD_KEEP_W;

logic [1:0]              beat_cnt_q;
logic                    accept;
logic [`MOLD_DATA_W-1:0] swapped;
logic                    hdr_valid_q;
mold_header_t            hdr_q;

function automatic logic [`MOLD_CNT_W-1:0] kept_count(input logic [`MOLD_KEEP_W-1:0] keep);
	logic [`MOLD_CNT_W-1:0] n;
	n = '0;
	for (int i = 0; i < `MOLD_KEEP_W; i++) begin
		n = n + {{(`MOLD_CNT_W-1){1'b0}}, keep[i]};
	end
	return n;
endfunction

// a new packet waits while the previous header is still pending
assign tready_o = room_i & ~((beat_cnt_q == 2'd0) & hdr_valid_q);
assign accept   = beat_i.valid & tready_o;

// lane 0 becomes the most significant byte
always_comb begin
	for (int i = 0; i < `MOLD_KEEP_W; i++) begin
		swapped[8*(`MOLD_KEEP_W-1-i) +: 8] = beat_i.data[8*i +: 8];
	end
end

always_comb begin
	push_o.cnt  = '0;
	push_o.data = beat_i.data;
	if (accept) begin
		if (beat_cnt_q == 2'd2) begin
			push_o.cnt  = kept_count(beat_i.keep >> HDR_LANES);
			push_o.data = beat_i.data >> (8 * HDR_LANES);
		end else if (beat_cnt_q == 2'd3) begin
			push_o.cnt = kept_count(beat_i.keep);
		end
	end
end

always_ff @(posedge clk) begin
	if (!nreset) begin
		beat_cnt_q  <= 2'd0;
		hdr_valid_q <= 1'b0;
	end else begin
		if (accept) begin
			if (beat_i.last)
				beat_cnt_q <= 2'd0;
			else if (beat_cnt_q != 2'd3)
				beat_cnt_q <= beat_cnt_q + 2'd1;
		end
		if (accept && beat_cnt_q == 2'd2)
			hdr_valid_q <= 1'b1;
		else if (hdr_take_i)
			hdr_valid_q <= 1'b0;
	end
end

// sid bytes 0-9, seq bytes 10-17, count bytes 18-19
always_ff @(posedge clk) begin
	if (accept) begin
		case (beat_cnt_q)
			2'd0: hdr_q.sid[79:16] <= swapped;
			2'd1: begin
				hdr_q.sid[15:0]  <= swapped[63:48];
				hdr_q.seq[63:16] <= swapped[47:0];
			end
			2'd2: begin
				hdr_q.seq[15:0] <= swapped[63:48];
				hdr_q.msg_cnt   <= swapped[47:32];
			end
			default: ;
		endcase
	end
end

assign hdr_o       = hdr_q;
assign hdr_valid_o = hdr_valid_q;

endmodule

`default_nettype wire

//--- verilog/mold_byte_buffer.sv
/*
 * Byte realignment buffer
 * shift store that drops popped bytes from the front and appends
 * pushed bytes behind the remaining ones, oldest byte at lane 0
 */
`include "mold_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module mold_byte_buffer
	import mold_pkg::*;
(
	input  wire                     clk,
	input  wire                     nreset,
	input  byte_push_t              push_i,
	input  wire [`MOLD_CNT_W-1:0]   pop_cnt_i,
	output logic [`MOLD_DATA_W-1:0] head_o,
	output logic [`MOLD_FILL_W-1:0] fill_o,
	output logic                    room_o
);

localparam int STORE_W = 8 * `MOLD_BUF_BYTES;
// room for one full beat
localparam int ROOM_MAX = `MOLD_BUF_BYTES - `MOLD_KEEP_W;

logic [STORE_W-1:0]      store_q;
logic [STORE_W-1:0]      store_next;
logic [STORE_W-1:0]      shifted;
logic [STORE_W-1:0]      keep_mask;
logic [STORE_W-1:0]      placed;
logic [`MOLD_FILL_W-1:0] fill_q;
logic [`MOLD_FILL_W-1:0] rem;

// bytes that stay after the pop
assign rem = fill_q - {{(`MOLD_FILL_W-`MOLD_CNT_W){1'b0}}, pop_cnt_i};

always_comb begin
	shifted   = store_q >> {pop_cnt_i, 3'b000};
	// clear stale bytes above the remaining ones
	keep_mask = ~({STORE_W{1'b1}} << {rem, 3'b000});
	placed    = {{(STORE_W-`MOLD_DATA_W){1'b0}}, push_i.data} << {rem, 3'b000};
	// lanes above push cnt land past the new fill level
	store_next = (shifted & keep_mask) | placed;
end

always_ff @(posedge clk) begin
	if (!nreset) begin
		fill_q <= '0;
	end else begin
		fill_q <= rem + {{(`MOLD_FILL_W-`MOLD_CNT_W){1'b0}}, push_i.cnt};
	end
end

always_ff @(posedge clk) begin
	store_q <= store_next;
end

assign head_o = store_q[`MOLD_DATA_W-1:0];
assign fill_o = fill_q;
assign room_o = (fill_q <= ROOM_MAX[`MOLD_FILL_W-1:0]);

endmodule

`default_nettype wire

//--- verilog/mold_msg_framer.sv
/*
 * MoldUDP64 message framer
 * loads the pending header, reads each 2 byte length field and cuts
 * the message body into 64 bit words with mask, start and last flags
 */
`include "mold_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module mold_msg_framer
	import mold_pkg::*;
(
	input  wire                     clk,
	input  wire                     nreset,
	input  mold_header_t            hdr_i,
	input  wire                     hdr_valid_i,
	input  wire [`MOLD_DATA_W-1:0]  head_i,
	input  wire [`MOLD_FILL_W-1:0]  fill_i,
	output logic                    hdr_take_o,
	output logic [`MOLD_CNT_W-1:0]  pop_cnt_o,
	output mold_word_t              msg_o,
	output mold_id_t                id_o
);

typedef enum logic [1:0] {ST_IDLE, ST_LEN, ST_BODY} state_t;

state_t                  state_q, state_next;
logic [`MOLD_ML_W-1:0]   cnt_q, cnt_next;
logic [`MOLD_ML_W-1:0]   len_q, len_next;
logic                    first_q, first_next;
logic [`MOLD_ML_W-1:0]   field_len;
logic [`MOLD_CNT_W-1:0]  take;
logic                    last_word;
logic                    load_hdr;
logic                    step_msg;
logic                    word_v;
logic [`MOLD_KEEP_W-1:0] word_mask;
logic [`MOLD_DATA_W-1:0] word_data;
logic [`MOLD_SID_W-1:0]  sid_q;
logic [`MOLD_SEQ_W-1:0]  seq_q;
mold_word_t              msg_q;
mold_id_t                id_q;

// big endian length field with byte 0 first
assign field_len = {head_i[7:0], head_i[15:8]};
assign last_word = (len_q <= `MOLD_KEEP_W);
assign take      = last_word ? len_q[`MOLD_CNT_W-1:0] : `MOLD_KEEP_W;

always_comb begin
	for (int i = 0; i < `MOLD_KEEP_W; i++) begin
		word_mask[i]          = (i < take);
		word_data[8*i +: 8]   = word_mask[i] ? head_i[8*i +: 8] : 8'h00;
	end
end

always_comb begin
	state_next = state_q;
	cnt_next   = cnt_q;
	len_next   = len_q;
	first_next = first_q;
	hdr_take_o = 1'b0;
	pop_cnt_o  = '0;
	load_hdr   = 1'b0;
	step_msg   = 1'b0;
	word_v     = 1'b0;
	case (state_q)
		ST_IDLE: if (hdr_valid_i) begin
			hdr_take_o = 1'b1;
			load_hdr   = 1'b1;
			cnt_next   = hdr_i.msg_cnt;
			// 0 and 0xffff carry no messages
			if (hdr_i.msg_cnt != '0 && hdr_i.msg_cnt != '1)
				state_next = ST_LEN;
		end
		ST_LEN: if (fill_i >= 2) begin
			pop_cnt_o = 2;
			if (field_len == '0) begin
				step_msg = 1'b1;
			end else begin
				len_next   = field_len;
				first_next = 1'b1;
				state_next = ST_BODY;
			end
		end
		default: if ({1'b0, take} <= fill_i) begin
			pop_cnt_o  = take;
			word_v     = 1'b1;
			len_next   = len_q - {{(`MOLD_ML_W-`MOLD_CNT_W){1'b0}}, take};
			first_next = 1'b0;
			step_msg   = last_word;
		end
	endcase
	if (step_msg) begin
		cnt_next   = cnt_q - 1'b1;
		state_next = (cnt_q == 1) ? ST_IDLE : ST_LEN;
	end
end

always_ff @(posedge clk) begin
	if (!nreset) begin
		state_q <= ST_IDLE;
		cnt_q   <= '0;
		len_q   <= '0;
		first_q <= 1'b0;
	end else begin
		state_q <= state_next;
		cnt_q   <= cnt_next;
		len_q   <= len_next;
		first_q <= first_next;
	end
end

always_ff @(posedge clk) begin
	if (load_hdr) begin
		sid_q <= hdr_i.sid;
		seq_q <= hdr_i.seq;
	end else if (step_msg) begin
		seq_q <= seq_q + 1'b1;
	end
end

// the word's identity is sampled before the sequence step
always_ff @(posedge clk) begin
	if (!nreset)
		msg_q.valid <= 1'b0;
	else
		msg_q.valid <= word_v;
	if (word_v) begin
		msg_q.start <= first_q;
		msg_q.last  <= last_word;
		msg_q.mask  <= word_mask;
		msg_q.data  <= word_data;
		id_q.sid    <= sid_q;
		id_q.seq    <= seq_q;
	end
end

assign msg_o = msg_q;
assign id_o  = id_q;

endmodule

`default_nettype wire

//--- verilog/moldudp64_rx.sv
/*
 * MoldUDP64 receiver top
 * header parser feeds the byte buffer, the framer turns the buffered
 * bytes into message words tagged with session id and sequence number
 */
`include "mold_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module moldudp64_rx
	import mold_pkg::*;
(
	input  wire        clk,
	input  wire        nreset,
	input  axis_beat_t udp_axis_i,
	output logic       udp_axis_tready_o,
	output mold_word_t mold_msg_o,
	output mold_id_t   mold_id_o
);

byte_push_t              push;
mold_header_t            hdr;
logic                    hdr_valid;
logic                    hdr_take;
logic                    room;
logic [`MOLD_DATA_W-1:0] head;
logic [`MOLD_FILL_W-1:0] fill;
logic [`MOLD_CNT_W-1:0]  pop_cnt;

mold_header_parse u_header_parse (
	.clk        (clk),
	.nreset     (nreset),
	.beat_i     (udp_axis_i),
	.room_i     (room),
	.hdr_take_i (hdr_take),
	.tready_o   (udp_axis_tready_o),
	.push_o     (push),
	.hdr_o      (hdr),
	.hdr_valid_o(hdr_valid)
);

mold_byte_buffer u_byte_buffer (
	.clk      (clk),
	.nreset   (nreset),
	.push_i   (push),
	.pop_cnt_i(pop_cnt),
	.head_o   (head),
	.fill_o   (fill),
	.room_o   (room)
);

mold_msg_framer u_msg_framer (
	.clk        (clk),
	.nreset     (nreset),
	.hdr_i      (hdr),
	.hdr_valid_i(hdr_valid),
	.head_i     (head),
	.fill_i     (fill),
	.hdr_take_o (hdr_take),
	.pop_cnt_o  (pop_cnt),
	.msg_o      (mold_msg_o),
	.id_o       (mold_id_o)
);

endmodule

`default_nettype wire

//--- sim/moldudp64_rx_props.sv
/*
 * Byte buffer properties
 * pops stay within the fill level, the fill stays within capacity
 * and pushes only arrive when they fit
 */
`include "mold_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module moldudp64_rx_props
	import mold_pkg::*;
(
	input wire                    clk,
	input wire                    nreset,
	input byte_push_t             push_i,
	input wire [`MOLD_CNT_W-1:0]  pop_cnt_i,
	input wire [`MOLD_FILL_W-1:0] fill_i,
	input wire                    room_i
);

int unsigned           fail_cnt = 0;
logic [`MOLD_FILL_W:0] after_push;

// fill level at the next edge
assign after_push = fill_i - pop_cnt_i + push_i.cnt;

pop_within_fill: assert property (@(posedge clk) disable iff (!nreset)
	pop_cnt_i <= fill_i)
	else begin
		$error("byte buffer popped more bytes than it holds");
		fail_cnt++;
	end

fill_within_capacity: assert property (@(posedge clk) disable iff (!nreset)
	fill_i <= `MOLD_BUF_BYTES)
	else begin
		$error("byte buffer fill level above its capacity");
		fail_cnt++;
	end

push_fits: assert property (@(posedge clk) disable iff (!nreset)
	(push_i.cnt != 0) |-> ($past(room_i) || after_push <= `MOLD_BUF_BYTES))
	else begin
		$error("byte buffer push without room");
		fail_cnt++;
	end

endmodule

bind mold_byte_buffer moldudp64_rx_props u_props (
	.clk      (clk),
	.nreset   (nreset),
	.push_i   (push_i),
	.pop_cnt_i(pop_cnt_i),
	.fill_i   (fill_o),
	.room_i   (room_o)
);

`default_nettype wire

//--- sim/moldudp64_rx_checker.sv
/*
 * MoldUDP64 receiver output checker
 * compares each valid output word, in order, with the expected words
 * queued by the testbench
 */
`include "mold_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module moldudp64_rx_checker
	import mold_pkg::*;
(
	input wire        clk,
	input wire        nreset,
	input mold_word_t msg_i,
	input mold_id_t   id_i
);

mold_word_t  exp_w[$];
mold_id_t    exp_id[$];
int unsigned errors = 0;
int unsigned words_seen = 0;

function automatic void add_expected(input mold_word_t w, input mold_id_t id);
	exp_w.push_back(w);
	exp_id.push_back(id);
endfunction

function automatic int pending();
	return exp_w.size();
endfunction

function automatic void report_missing();
	if (exp_w.size() != 0) begin
		$display("%0d expected message words never appeared at the output", exp_w.size());
		errors = errors + exp_w.size();
	end
endfunction

// data bits covered by a byte mask
function automatic logic [`MOLD_DATA_W-1:0] byte_lanes(input logic [`MOLD_KEEP_W-1:0] mask);
	logic [`MOLD_DATA_W-1:0] lanes;
	for (int i = 0; i < `MOLD_KEEP_W; i++)
		lanes[8*i +: 8] = {8{mask[i]}};
	return lanes;
endfunction

// registered outputs are settled at the falling edge
always @(negedge clk) begin : compare
	mold_word_t              w;
	mold_id_t                id;
	logic [`MOLD_DATA_W-1:0] lanes;
	if (nreset && $isunknown(msg_i.valid)) begin
		$display("output valid is unknown at %0t", $time);
		errors++;
	end
	if (nreset && msg_i.valid === 1'b1) begin
		words_seen++;
		if (exp_w.size() == 0) begin
			$display("unexpected message word at %0t, no word was expected", $time);
			errors++;
		end else begin
			w = exp_w.pop_front();
			id = exp_id.pop_front();
			lanes = byte_lanes(w.mask);
			if ({msg_i.start, msg_i.last, msg_i.mask} !== {w.start, w.last, w.mask}) begin
				$display("FAILED @%0t: word %0d flags %b%b mask %h, expected %b%b %h",
					$time, words_seen, msg_i.start, msg_i.last, msg_i.mask,
					w.start, w.last, w.mask);
				errors++;
			end
			if ((msg_i.data & lanes) !== (w.data & lanes)) begin
				$display("FAILED @%0t: word %0d data %h, expected %h",
					$time, words_seen, msg_i.data & lanes, w.data & lanes);
				errors++;
			end
			if (id_i !== id) begin
				$display("FAILED @%0t: word %0d sid %h seq %h, expected sid %h seq %h",
					$time, words_seen, id_i.sid, id_i.seq, id.sid, id.seq);
				errors++;
			end
		end
	end
end

endmodule

`default_nettype wire

//--- sim/moldudp64_rx_tb.sv
/*
 * MoldUDP64 receiver testbench
 * directed and random packets, a reference model of the message framing
 * and a watchdog
 */
`include "mold_settings.svh"
`timescale 1ns/1ps
`default_nettype none

module moldudp64_rx_tb
	import mold_pkg::*;
();

logic        clk;
logic        nreset;
axis_beat_t  udp_axis;
logic        tready;
mold_word_t  mold_msg;
mold_id_t    mold_id;
integer      seed;
int unsigned budget = 200;
int unsigned tb_errors = 0;
logic [7:0]  pkt_bytes[$];
int          lens[$];

moldudp64_rx u_dut (
	.clk              (clk),
	.nreset           (nreset),
	.udp_axis_i       (udp_axis),
	.udp_axis_tready_o(tready),
	.mold_msg_o       (mold_msg),
	.mold_id_o        (mold_id)
);

moldudp64_rx_checker u_check (
	.clk   (clk),
	.nreset(nreset),
	.msg_i (mold_msg),
	.id_i  (mold_id)
);

initial begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

// reference model building the packet bytes from lens and the expected DUT words
function automatic void build_packet(input logic [`MOLD_SID_W-1:0] sid,
	input logic [`MOLD_SEQ_W-1:0] seq, input logic [`MOLD_ML_W-1:0] cnt_field);
	mold_word_t  w;
	mold_id_t    id;
	logic [15:0] len;
	int          base;
	int          chunk;
	pkt_bytes.delete();
	for (int i = `MOLD_SID_W/8 - 1; i >= 0; i--)
		pkt_bytes.push_back(sid[8*i +: 8]);
	for (int i = `MOLD_SEQ_W/8 - 1; i >= 0; i--)
		pkt_bytes.push_back(seq[8*i +: 8]);
	pkt_bytes.push_back(cnt_field[15:8]);
	pkt_bytes.push_back(cnt_field[7:0]);
	for (int m = 0; m < lens.size(); m++) begin
		len = 16'(lens[m]);
		pkt_bytes.push_back(len[15:8]);
		pkt_bytes.push_back(len[7:0]);
		base = pkt_bytes.size();
		for (int i = 0; i < len; i++)
			pkt_bytes.push_back(8'($random(seed)));
		id.sid = sid;
		id.seq = seq + m;
		// 8 bytes per word with a possibly partial final one
		for (int n = 0; n < len; n += 8) begin
			chunk = (len - n < 8) ? len - n : 8;
			w = '0;
			w.valid = 1'b1;
			w.start = (n == 0);
			w.last = (n + chunk == len);
			for (int j = 0; j < chunk; j++) begin
				w.mask[j] = 1'b1;
				w.data[8*j +: 8] = pkt_bytes[base + n + j];
			end
			u_check.add_expected(w, id);
		end
	end
endfunction

// beats change on falling edges and are held until tready lets them through
task automatic send_packet(input int gap_pct);
	int nbeats;
	budget = budget + 40 + 2 * pkt_bytes.size();
	nbeats = (pkt_bytes.size() + 7) / 8;
	for (int b = 0; b < nbeats; b++) begin
		while (gap_pct > 0 && $unsigned($random(seed)) % 100 < gap_pct) begin
			udp_axis.valid = 1'b0;
			@(negedge clk);
		end
		udp_axis = '0;
		udp_axis.valid = 1'b1;
		udp_axis.last = (b == nbeats - 1);
		for (int j = 0; j < `MOLD_KEEP_W; j++) begin
			if (8*b + j < pkt_bytes.size()) begin
				udp_axis.keep[j] = 1'b1;
				udp_axis.data[8*j +: 8] = pkt_bytes[8*b + j];
			end
		end
		while (!tready)
			@(negedge clk);
		@(negedge clk);
	end
	udp_axis.valid = 1'b0;
endtask

task automatic wait_drain();
	while (u_check.pending() != 0)
		@(negedge clk);
	// idle cycles to catch stray words
	repeat (4) @(negedge clk);
endtask

initial begin : main
	int          n;
	logic [95:0] r;
	int unsigned total;
	seed = 32'h9fd97b98;
	udp_axis = '0;
	nreset = 1'b0;
	repeat (5) @(negedge clk);
	nreset = 1'b1;
	@(negedge clk);
	if (tready !== 1'b1) begin
		$display("FAILED @%0t: tready is not high after reset", $time);
		tb_errors++;
	end
	// quiet interval in which any word is unexpected
	repeat (10) @(negedge clk);

	lens = {1, 8, 9, 30};
	build_packet(80'h0123456789abcdef0011, 64'h1000, 16'd4);
	send_packet(0);
	wait_drain();

	// empty counts followed by a packet that must still decode
	lens.delete();
	build_packet(80'h11, 64'h2000, 16'h0000);
	send_packet(0);
	build_packet(80'h22, 64'h3000, 16'hffff);
	send_packet(0);
	lens = {5, 16};
	build_packet(80'h33, 64'h4000, 16'd2);
	send_packet(10);
	wait_drain();

	// zero-length messages still take a sequence number
	lens = {3, 0, 12};
	build_packet(80'h44, 64'hffff_ffff_ffff_fffe, 16'd3);
	send_packet(0);
	lens = {0, 7, 0};
	build_packet(80'h55, 64'h5000, 16'd3);
	send_packet(0);
	wait_drain();

	for (int p = 0; p < 200; p++) begin
		lens.delete();
		n = 1 + $unsigned($random(seed)) % 6;
		for (int m = 0; m < n; m++)
			lens.push_back($unsigned($random(seed)) % 41);
		r = {$random(seed), $random(seed), $random(seed)};
		build_packet(r[79:0], {$random(seed), $random(seed)}, 16'(n));
		send_packet(25);
	end
	wait_drain();

	total = tb_errors + u_check.errors + u_dut.u_byte_buffer.u_props.fail_cnt;
	$display("errors: %0d checker, %0d testbench, %0d assertion, %0d words checked",
		u_check.errors, tb_errors, u_dut.u_byte_buffer.u_props.fail_cnt,
		u_check.words_seen);
	if (total == 0)
		$display("Test OK");
	else
		$display("Test FAILED");
	$finish;
end

// budget grows with every packet sent
initial begin : watchdog
	int unsigned cycles;
	cycles = 0;
	while (cycles <= budget) begin
		@(posedge clk);
		cycles++;
	end
	$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
	u_check.report_missing();
	$display("Test FAILED");
	$finish;
end

endmodule

`default_nettype wire

//--- all.f
+incdir+verilog
verilog/mold_pkg.sv
verilog/mold_header_parse.sv
verilog/mold_byte_buffer.sv
verilog/mold_msg_framer.sv
verilog/moldudp64_rx.sv
sim/moldudp64_rx_props.sv
sim/moldudp64_rx_checker.sv
sim/moldudp64_rx_tb.sv

//--- Makefile
# MoldUDP64 receiver simulation and lint with Verilator

VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= moldudp64_rx_tb
RTL_TOP    ?= moldudp64_rx
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 4
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -j $(JOBS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: build
	$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test OK$$" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
